/* rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// ====================
// Group and register file sizing
// ====================

`define ISSUE_WIDTH 2   // Lanes per rename group

`define ARCH_REGS 32
`define PHYS_REGS 64

`define ARCH_W 5        // Arch register index
`define PHYS_W 6        // Phys register index

`define XLEN 32

// Phys registers not holding an initial arch mapping
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)

`endif

/* rename_pkg.sv */
`default_nettype none

package rename_pkg;

`include "rename_config.svh"

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP      = 7'b0110011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_LOAD    = 7'b0000011,
        OPC_STORE   = 7'b0100011,
        OPC_BRANCH  = 7'b1100011,
        OPC_LUI     = 7'b0110111,
        OPC_JAL     = 7'b1101111,
        OPC_ILLEGAL = 7'b0000000   // Anything outside the set above
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_ALU_IMM, CLS_LOAD, CLS_STORE,
        CLS_BRANCH, CLS_LUI, CLS_JAL, CLS_INVALID
    } op_class_e;

    typedef struct packed {
        op_class_e           op_class;
        logic [`ARCH_W-1:0]  rs1;
        logic [`ARCH_W-1:0]  rs2;
        logic [`ARCH_W-1:0]  rd;
        logic                use_rs1;
        logic                use_rs2;
        logic                writes_rd;   // Never set for rd x0
    } decoded_t;

    // One lane from fetch
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   instr;
        logic [`XLEN-1:0]   pc;
    } lane_in_t;

    // One renamed lane toward dispatch
    typedef struct packed {
        logic               valid;
        op_class_e          op_class;
        logic [`PHYS_W-1:0] rs1_phys;
        logic [`PHYS_W-1:0] rs2_phys;
        logic [`PHYS_W-1:0] rd_phys;
        logic [`ARCH_W-1:0] rd_arch;
        logic               writes_rd;
        logic [`XLEN-1:0]   pc;
    } issued_uop_t;

endpackage

`default_nettype wire

/* rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rv_decoder (
    input  logic [`XLEN-1:0]     instr_i,
    output rename_pkg::decoded_t dec_o
);

    import rename_pkg::*;

    opcode_e opc;

    // Fold every unknown major opcode onto OPC_ILLEGAL
    always_comb begin
        case (instr_i[6:0])
            OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE,
            OPC_BRANCH, OPC_LUI, OPC_JAL: opc = opcode_e'(instr_i[6:0]);
            default:                      opc = OPC_ILLEGAL;
        endcase
    end

    always_comb begin
        dec_o = '0;
        dec_o.rd  = instr_i[11:7];
        dec_o.rs1 = instr_i[19:15];
        dec_o.rs2 = instr_i[24:20];

        case (opc)
            OPC_OP: begin
                dec_o.op_class  = CLS_ALU;
                dec_o.use_rs1   = 1'b1;
                dec_o.use_rs2   = 1'b1;
                dec_o.writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_o.op_class  = CLS_ALU_IMM;
                dec_o.use_rs1   = 1'b1;
                dec_o.writes_rd = 1'b1;
            end
            OPC_LOAD: begin
                dec_o.op_class  = CLS_LOAD;
                dec_o.use_rs1   = 1'b1;
                dec_o.writes_rd = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                dec_o.op_class = (opc == OPC_STORE) ? CLS_STORE : CLS_BRANCH;
                dec_o.use_rs1  = 1'b1;
                dec_o.use_rs2  = 1'b1;   // No destination
            end
            OPC_LUI, OPC_JAL: begin
                dec_o.op_class  = (opc == OPC_LUI) ? CLS_LUI : CLS_JAL;
                dec_o.writes_rd = 1'b1;
            end
            default: dec_o.op_class = CLS_INVALID;   // No register use
        endcase

        // Writes to x0 are dropped
        if (dec_o.rd == '0) begin
            dec_o.writes_rd = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* register_alias_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module register_alias_table (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [`ISSUE_WIDTH-1:0][1:0][`ARCH_W-1:0]   src_arch_i,  // [lane][rs1,rs2]
    input  rename_pkg::decoded_t [`ISSUE_WIDTH-1:0]     dec_i,
    input  logic [`ISSUE_WIDTH-1:0]                     alloc_i,
    input  logic [`ISSUE_WIDTH-1:0][`PHYS_W-1:0]        new_phys_i,
    output logic [`ISSUE_WIDTH-1:0][1:0][`PHYS_W-1:0]   src_phys_o
);

    logic [`PHYS_W-1:0]             map_q [`ARCH_REGS];
    logic [`ISSUE_WIDTH-1:0][1:0]   src_use;

    // ====================
    // Lookup with in-group bypass
    // ====================

    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            src_use[l] = {dec_i[l].use_rs2, dec_i[l].use_rs1};
        end
    end

    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            for (int s = 0; s < 2; s++) begin
                if (!src_use[l][s] || src_arch_i[l][s] == '0) begin
                    src_phys_o[l][s] = '0;   // x0 and unused sources
                end else begin
                    src_phys_o[l][s] = map_q[src_arch_i[l][s]];
                end
                // Nearest older lane writing this register wins
                for (int o = 0; o < l; o++) begin
                    if (alloc_i[o] && src_use[l][s] && src_arch_i[l][s] == dec_i[o].rd) begin
                        src_phys_o[l][s] = new_phys_i[o];
                    end
                end
            end
        end
    end

    // ====================
    // Map table update
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= `PHYS_W'(i);   // Identity mapping
            end
        end else begin
            // Later lanes written last so the youngest mapping sticks
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                if (alloc_i[l]) begin
                    map_q[dec_i[l].rd] <= new_phys_i[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module free_list (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [`ISSUE_WIDTH-1:0]                 pop_i,
    input  logic                                    push_i,
    input  logic [`PHYS_W-1:0]                      push_phys_i,
    output logic [`ISSUE_WIDTH-1:0][`PHYS_W-1:0]    head_o,
    output logic                                    enough_o
);

    localparam int PTR_W = $clog2(`FREE_DEPTH);
    localparam int CNT_W = $clog2(`FREE_DEPTH + 1);

    logic [`PHYS_W-1:0] fifo_q [`FREE_DEPTH];
    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   tail_q;
    logic [CNT_W-1:0]   count_q;
    logic [CNT_W-1:0]   count_d;
    logic [CNT_W-1:0]   pop_cnt;

    // Number of lanes taking a register this cycle
    always_comb begin
        pop_cnt = '0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            pop_cnt = pop_cnt + CNT_W'(pop_i[l]);
        end
    end

    assign count_d = count_q + CNT_W'(push_i) - pop_cnt;

    // Oldest entries first, pointer wraps on its own width
    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            head_o[l] = fifo_q[head_q + PTR_W'(l)];
        end
    end

    // ====================
    // Queue state
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                fifo_q[i] <= `PHYS_W'(`ARCH_REGS + i);
            end
            head_q   <= '0;
            tail_q   <= '0;               // Full, so tail sits on head
            count_q  <= CNT_W'(`FREE_DEPTH);
            enough_o <= 1'b0;             // Low through reset
        end else begin
            if (push_i) begin
                fifo_q[tail_q] <= push_phys_i;
                tail_q         <= tail_q + PTR_W'(1);
            end
            head_q   <= head_q + PTR_W'(pop_cnt);
            count_q  <= count_d;
            enough_o <= (count_d >= CNT_W'(`ISSUE_WIDTH));
        end
    end

endmodule

`default_nettype wire

/* issue_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module issue_regs (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        accept_i,
    input  logic                                        clear_i,   // Flush or bubble
    input  rename_pkg::issued_uop_t [`ISSUE_WIDTH-1:0]  uop_i,
    output rename_pkg::issued_uop_t [`ISSUE_WIDTH-1:0]  uop_o
);

    import rename_pkg::*;

    issued_uop_t [`ISSUE_WIDTH-1:0] uop_q;
    logic [`ISSUE_WIDTH-1:0]        valid_q;
    logic                           load;

    assign load = accept_i & ~clear_i;

    // Valids last exactly one cycle per accept
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
        end else begin
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                valid_q[l] <= load & uop_i[l].valid;
            end
        end
    end

    // Payload held until the next accept
    always_ff @(posedge clk) begin
        if (load) begin
            uop_q <= uop_i;
        end
    end

    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            uop_o[l]       = uop_q[l];
            uop_o[l].valid = valid_q[l];
        end
    end

endmodule

`default_nettype wire

/* issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module issue_stage (
    input  logic                                        clk,
    input  logic                                        reset,
    input  rename_pkg::lane_in_t [`ISSUE_WIDTH-1:0]     fetch_i,
    input  logic                                        dispatch_ready_i,
    input  logic                                        flush_i,
    input  logic                                        bubble_i,
    input  logic                                        commit_valid_i,
    input  logic [`PHYS_W-1:0]                          commit_phys_i,
    output logic                                        decode_ready_o,
    output rename_pkg::issued_uop_t [`ISSUE_WIDTH-1:0]  issue_o
);

    import rename_pkg::*;

    decoded_t [`ISSUE_WIDTH-1:0]                dec;
    logic [`ISSUE_WIDTH-1:0][1:0][`ARCH_W-1:0]  src_arch;
    logic [`ISSUE_WIDTH-1:0][1:0][`PHYS_W-1:0]  src_phys;
    logic [`ISSUE_WIDTH-1:0][`PHYS_W-1:0]       head;
    logic [`ISSUE_WIDTH-1:0][`PHYS_W-1:0]       new_phys;
    logic [`ISSUE_WIDTH-1:0]                    want_rd;
    logic [`ISSUE_WIDTH-1:0]                    alloc;
    logic                                       enough;
    issued_uop_t [`ISSUE_WIDTH-1:0]             uop;

    // ====================
    // Decode per lane
    // ====================

    for (genvar l = 0; l < `ISSUE_WIDTH; l++) begin : g_lane
        rv_decoder u_dec (
            .instr_i (fetch_i[l].instr),
            .dec_o   (dec[l])
        );
        assign src_arch[l] = {dec[l].rs2, dec[l].rs1};
        assign want_rd[l]  = fetch_i[l].valid & dec[l].writes_rd;   // rd x0 already excluded
    end

    assign decode_ready_o = dispatch_ready_i & enough & ~flush_i & ~bubble_i;
    assign alloc          = want_rd & {`ISSUE_WIDTH{decode_ready_o}};

    // Each writing lane takes the next unused head entry
    always_comb begin
        int slot;
        slot = 0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            new_phys[l] = head[slot];
            if (want_rd[l]) begin
                slot++;
            end
        end
    end

    register_alias_table u_rat (
        .clk        (clk),
        .reset      (reset),
        .src_arch_i (src_arch),
        .dec_i      (dec),
        .alloc_i    (alloc),
        .new_phys_i (new_phys),
        .src_phys_o (src_phys)
    );

    free_list u_free (
        .clk         (clk),
        .reset       (reset),
        .pop_i       (alloc),
        .push_i      (commit_valid_i),
        .push_phys_i (commit_phys_i),
        .head_o      (head),
        .enough_o    (enough)
    );

    // ====================
    // Uop assembly
    // ====================

    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            uop[l].valid     = fetch_i[l].valid;
            uop[l].op_class  = dec[l].op_class;
            uop[l].rs1_phys  = src_phys[l][0];
            uop[l].rs2_phys  = src_phys[l][1];
            uop[l].rd_phys   = want_rd[l] ? new_phys[l] : '0;
            uop[l].rd_arch   = dec[l].rd;
            uop[l].writes_rd = dec[l].writes_rd;
            uop[l].pc        = fetch_i[l].pc;
        end
    end

    issue_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .accept_i (decode_ready_o),
        .clear_i  (flush_i | bubble_i),
        .uop_i    (uop),
        .uop_o    (issue_o)
    );

endmodule

`default_nettype wire

/* issue_stage_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module issue_stage_properties (
    input logic                                         clk,
    input logic                                         reset,
    input logic                                         flush_i,
    input logic                                         bubble_i,
    input logic                                         decode_ready_o,
    input rename_pkg::issued_uop_t [`ISSUE_WIDTH-1:0]   issue_o
);

    int failures = 0;   // Read by the testbench at the end of the run

    a_no_accept_on_clear: assert property (@(posedge clk) disable iff (!reset)
        (flush_i || bubble_i) |-> !decode_ready_o)
        else begin
            $error("decode_ready_o high during flush or bubble");
            failures++;
        end

    for (genvar l = 0; l < `ISSUE_WIDTH; l++) begin : g_lane
        a_rd_not_zero: assert property (@(posedge clk) disable iff (!reset)
            (issue_o[l].valid && issue_o[l].writes_rd) |-> (issue_o[l].rd_phys != '0))
            else begin
                $error("Writing lane %0d issued with rd_phys 0", l);
                failures++;
            end
    end

    // Both lanes writing need distinct destinations
    a_rd_distinct: assert property (@(posedge clk) disable iff (!reset)
        (issue_o[0].valid && issue_o[0].writes_rd && issue_o[1].valid && issue_o[1].writes_rd)
        |-> (issue_o[0].rd_phys != issue_o[1].rd_phys))
        else begin
            $error("Both lanes issued the same rd_phys");
            failures++;
        end

    a_flush_drops: assert property (@(posedge clk) disable iff (!reset)
        flush_i |=> !(issue_o[0].valid || issue_o[1].valid))
        else begin
            $error("Issue valid high the cycle after a flush");
            failures++;
        end

endmodule

bind issue_stage issue_stage_properties u_props (
    .clk            (clk),
    .reset          (reset),
    .flush_i        (flush_i),
    .bubble_i       (bubble_i),
    .decode_ready_o (decode_ready_o),
    .issue_o        (issue_o)
);

`default_nettype wire

/* tb_issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module tb_issue_stage;

    import rename_pkg::*;

    localparam int RUN_CYCLES     = 2000;                          // Sum of the test lengths
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;

    logic                           clk;
    logic                           reset;
    lane_in_t [`ISSUE_WIDTH-1:0]    fetch_i;
    logic                           dispatch_ready_i;
    logic                           flush_i;
    logic                           bubble_i;
    logic                           commit_valid_i;
    logic [`PHYS_W-1:0]             commit_phys_i;
    logic                           decode_ready_o;
    issued_uop_t [`ISSUE_WIDTH-1:0] issue_o;

    // ====================
    // Reference model state
    // ====================

    logic [`PHYS_W-1:0]             rat_m [`ARCH_REGS];
    logic [`PHYS_W-1:0]             free_m [$];
    logic [`PHYS_W-1:0]             retire_m [$];   // Displaced mappings waiting for commit
    issued_uop_t [`ISSUE_WIDTH-1:0] exp_uop;
    logic                           exp_issue;      // Last edge accepted a group
    lane_in_t [`ISSUE_WIDTH-1:0]    group;
    logic                           take_new;
    logic [`XLEN-1:0]               pc_next;

    logic [31:0]        rng;
    int                 ready_low_pct;
    int                 flush_pct;
    int                 bubble_pct;
    int                 commit_pct;
    int                 illegal_pct;
    logic [`ARCH_W-1:0] reg_mask;                   // Small masks force bypass hits
    int                 checks;
    int                 errors;
    int                 errors_logged;
    int                 cycle_count = 0;

    issue_stage UUT (
        .clk              (clk),
        .reset            (reset),
        .fetch_i          (fetch_i),
        .dispatch_ready_i (dispatch_ready_i),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .commit_valid_i   (commit_valid_i),
        .commit_phys_i    (commit_phys_i),
        .decode_ready_o   (decode_ready_o),
        .issue_o          (issue_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic int roll();   // 0 to 99
        return int'((lcg_next() >> 8) % 32'd100);
    endfunction

    function automatic logic [`XLEN-1:0] make_instr();
        logic [`XLEN-1:0] bits;
        logic [6:0]       opc;
        case (roll() % 7)
            0:       opc = 7'b0110011;   // OP
            1:       opc = 7'b0010011;   // OP_IMM
            2:       opc = 7'b0000011;   // LOAD
            3:       opc = 7'b0100011;   // STORE
            4:       opc = 7'b1100011;   // BRANCH
            5:       opc = 7'b0110111;   // LUI
            default: opc = 7'b1101111;   // JAL
        endcase
        if (roll() < illegal_pct) begin
            opc = (roll() < 50) ? 7'b1110011 : 7'b0001111;   // SYSTEM or FENCE
        end
        bits        = lcg_next();
        bits[24:20] = bits[24:20] & reg_mask;
        bits[19:15] = bits[19:15] & reg_mask;
        bits[11:7]  = bits[11:7] & reg_mask;
        bits[6:0]   = opc;
        return bits;
    endfunction

    // Row is class, use_rs1, use_rs2, writes_rd
    function automatic decoded_t expect_decode(input logic [`XLEN-1:0] instr);
        decoded_t   d;
        logic [5:0] row;
        case (instr[6:0])
            7'b0110011: row = {CLS_ALU,     3'b111};
            7'b0010011: row = {CLS_ALU_IMM, 3'b101};
            7'b0000011: row = {CLS_LOAD,    3'b101};
            7'b0100011: row = {CLS_STORE,   3'b110};
            7'b1100011: row = {CLS_BRANCH,  3'b110};
            7'b0110111: row = {CLS_LUI,     3'b001};
            7'b1101111: row = {CLS_JAL,     3'b001};
            default:    row = {CLS_INVALID, 3'b000};
        endcase
        d.op_class  = op_class_e'(row[5:3]);
        d.use_rs1   = row[2];
        d.use_rs2   = row[1];
        d.writes_rd = row[0] && (instr[11:7] != '0);
        d.rs1       = instr[19:15];
        d.rs2       = instr[24:20];
        d.rd        = instr[11:7];
        return d;
    endfunction

    function automatic logic [`PHYS_W-1:0] map_source(input logic used,
                                                      input logic [`ARCH_W-1:0] arch);
        if (!used || arch == '0) begin
            return '0;
        end
        return rat_m[arch];
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic step_cycle();
        decoded_t [`ISSUE_WIDTH-1:0]          dec;
        logic [`ISSUE_WIDTH-1:0]              alloc;
        logic [`ISSUE_WIDTH-1:0][`PHYS_W-1:0] new_phys;
        logic                                 accept;
        int                                   slot;

        @(negedge clk);
        if (take_new) begin
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                group[l].valid = (roll() < 85);
                group[l].instr = make_instr();
                group[l].pc    = pc_next;
                pc_next        = pc_next + 32'd4;
            end
        end
        fetch_i          = group;   // Held until accepted
        dispatch_ready_i = (roll() >= ready_low_pct);
        flush_i          = (roll() < flush_pct);
        bubble_i         = (roll() < bubble_pct);
        commit_valid_i   = 1'b0;
        if (retire_m.size() > 0 && roll() < commit_pct) begin
            commit_valid_i = 1'b1;
            commit_phys_i  = retire_m.pop_front();
        end
        #1;

        // Outputs from the previous edge
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            compare_value($sformatf("issue_o[%0d].valid", l), 64'(issue_o[l].valid),
                          64'(exp_issue && exp_uop[l].valid));
            if (exp_issue && exp_uop[l].valid) begin
                compare_value($sformatf("issue_o[%0d]", l), 64'(issue_o[l]), 64'(exp_uop[l]));
            end
        end

        accept = dispatch_ready_i && (free_m.size() >= `ISSUE_WIDTH) && !flush_i && !bubble_i;
        compare_value("decode_ready_o", 64'(decode_ready_o), 64'(accept));

        slot = 0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            dec[l]      = expect_decode(group[l].instr);
            alloc[l]    = accept && group[l].valid && dec[l].writes_rd;
            new_phys[l] = '0;
            if (alloc[l]) begin
                new_phys[l] = free_m[slot];   // Next unused free entry
                slot++;
            end
        end

        if (accept) begin
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                exp_uop[l].valid     = group[l].valid;
                exp_uop[l].op_class  = dec[l].op_class;
                exp_uop[l].rs1_phys  = map_source(dec[l].use_rs1, dec[l].rs1);
                exp_uop[l].rs2_phys  = map_source(dec[l].use_rs2, dec[l].rs2);
                // Younger lane sees the older lane's new mapping
                for (int o = 0; o < l; o++) begin
                    if (alloc[o] && dec[l].use_rs1 && dec[l].rs1 == dec[o].rd) begin
                        exp_uop[l].rs1_phys = new_phys[o];
                    end
                    if (alloc[o] && dec[l].use_rs2 && dec[l].rs2 == dec[o].rd) begin
                        exp_uop[l].rs2_phys = new_phys[o];
                    end
                end
                exp_uop[l].rd_phys   = new_phys[l];
                exp_uop[l].rd_arch   = dec[l].rd;
                exp_uop[l].writes_rd = dec[l].writes_rd;
                exp_uop[l].pc        = group[l].pc;
            end
            for (int l = 0; l < `ISSUE_WIDTH; l++) begin
                if (alloc[l]) begin
                    retire_m.push_back(rat_m[dec[l].rd]);
                    rat_m[dec[l].rd] = new_phys[l];
                    free_m.delete(0);
                end
            end
        end

        if (commit_valid_i) begin
            free_m.push_back(commit_phys_i);   // Poppable after this edge
        end
        exp_issue = accept;
        take_new  = accept;
    endtask

    task automatic run_test(input string name, input int cycles, input int ready_low,
                            input int flush, input int bubble, input int commit,
                            input int illegal, input logic [`ARCH_W-1:0] mask);
        ready_low_pct = ready_low;
        flush_pct     = flush;
        bubble_pct    = bubble;
        commit_pct    = commit;
        illegal_pct   = illegal;
        reg_mask      = mask;
        repeat (cycles) step_cycle();
        $display("Test %s: %0d cycles, %0d errors", name, cycles, errors - errors_logged);
        errors_logged = errors;
    endtask

    initial begin
        rng              = 32'h69ff_9b48;
        reset            = 1'b0;
        fetch_i          = '0;
        dispatch_ready_i = 1'b1;   // Reset alone must keep decode_ready_o low
        flush_i          = 1'b0;
        bubble_i         = 1'b0;
        commit_valid_i   = 1'b0;
        commit_phys_i    = '0;
        group            = '0;
        exp_uop          = '0;
        exp_issue        = 1'b0;
        take_new         = 1'b0;
        pc_next          = 32'h0000_1000;
        ready_low_pct    = 0;
        flush_pct        = 0;
        bubble_pct       = 0;
        commit_pct       = 0;
        illegal_pct      = 0;
        reg_mask         = '1;
        checks           = 0;
        errors           = 0;
        errors_logged    = 0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            rat_m[i] = `PHYS_W'(i);
        end
        for (int i = 0; i < `FREE_DEPTH; i++) begin
            free_m.push_back(`PHYS_W'(`ARCH_REGS + i));
        end

        repeat (3) begin
            @(negedge clk);
            compare_value("decode_ready_o", 64'(decode_ready_o), 64'd0);
            compare_value("issue_o[0].valid", 64'(issue_o[0].valid), 64'd0);
            compare_value("issue_o[1].valid", 64'(issue_o[1].valid), 64'd0);
        end
        reset            = 1'b1;
        #1;
        compare_value("decode_ready_o", 64'(decode_ready_o), 64'd0);   // Free count not seen yet

        // add x5, x1, x2 then addi x6, x5, 1
        group[0].valid = 1'b1;
        group[0].instr = 32'h0020_82b3;
        group[0].pc    = pc_next;
        group[1].valid = 1'b1;
        group[1].instr = 32'h0012_8313;
        group[1].pc    = pc_next + 32'd4;
        pc_next        = pc_next + 32'd8;
        step_cycle();
        @(posedge clk);
        #1;
        compare_value("issue_o[0].rd_phys", 64'(issue_o[0].rd_phys), 64'd32);
        compare_value("issue_o[1].rd_phys", 64'(issue_o[1].rd_phys), 64'd33);
        compare_value("issue_o[1].rs1_phys", 64'(issue_o[1].rs1_phys), 64'd32);

        run_test("reset_first_rename", 99, 5, 0, 0, 60, 0, 5'h1f);
        run_test("rename_bypass", 500, 5, 2, 2, 60, 0, 5'h07);
        run_test("flush_bubble", 400, 5, 15, 15, 60, 5, 5'h1f);
        run_test("dispatch_stall", 400, 50, 2, 2, 60, 5, 5'h0f);
        run_test("free_list_drain", 400, 5, 2, 2, 15, 0, 5'h1f);
        run_test("decode_classes", 200, 5, 2, 2, 60, 40, 5'h1f);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_props.failures);
        if (errors == 0 && UUT.u_props.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
rename_pkg.sv
rv_decoder.sv
register_alias_table.sv
free_list.sv
issue_regs.sv
issue_stage.sv
issue_stage_properties.sv
tb_issue_stage.sv

/* Makefile */
TOP := tb_issue_stage
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
